// File: verilog/dense_pkg.sv
package dense_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [11:0] addr_t;
    typedef logic [15:0] file_id_t;

    typedef enum logic {
        DIR_READ  = 1'b0,
        DIR_WRITE = 1'b1
    } link_dir_t;

    typedef struct packed {
        logic      start;
        file_id_t  file_id;
        link_dir_t dir;
    } xfer_cmd_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        byte_t data;
    } ram_wr_t;

    typedef enum logic [2:0] {
        XF_IDLE,
        XF_HEAD,
        XF_WAIT,
        XF_RECV,
        XF_SEND,
        XF_DONE
    } xfer_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_RD_INPUT,
        SEQ_RD_MATRIX,
        SEQ_RD_BIAS,
        SEQ_COMPUTE,
        SEQ_WR_ANSWER
    } seq_state_t;

    typedef enum logic [2:0] {
        MAC_IDLE,
        MAC_BIAS,
        MAC_LOAD,
        MAC_RUN,
        MAC_WRITE
    } mac_state_t;

    localparam byte_t HEAD_READ  = 8'd82;  // 'R'
    localparam byte_t HEAD_WRITE = 8'd87;  // 'W'

    localparam file_id_t FILE_INPUT  = 16'd2402;
    localparam file_id_t FILE_MATRIX = 16'd2406;
    localparam file_id_t FILE_BIAS   = 16'd2446;
    localparam file_id_t FILE_ANSWER = 16'd2447;

    localparam int RAM_DEPTH = 4096;  // Whole addr_t range

    // Files sit back to back from address 0
    function automatic addr_t file_base(file_id_t id, int in_len, int out_len);
        int base;
        case (id)
            FILE_INPUT:  base = 0;
            FILE_MATRIX: base = in_len;
            FILE_BIAS:   base = in_len + in_len * out_len;
            FILE_ANSWER: base = in_len + in_len * out_len + out_len;
            default:     base = 0;
        endcase
        return addr_t'(base);
    endfunction

    function automatic addr_t file_len(file_id_t id, int in_len, int out_len);
        int len;
        case (id)
            FILE_INPUT:  len = in_len;
            FILE_MATRIX: len = in_len * out_len;  // One row per output
            FILE_BIAS:   len = out_len;
            FILE_ANSWER: len = out_len;
            default:     len = 0;
        endcase
        return addr_t'(len);
    endfunction

endpackage

// File: verilog/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram (
    input  logic               clk,
    input  dense_pkg::ram_wr_t wr_xfer,
    input  dense_pkg::ram_wr_t wr_mac,
    input  dense_pkg::addr_t   rd_addr0,
    input  dense_pkg::addr_t   rd_addr1,
    input  dense_pkg::addr_t   rd_addr2,
    output dense_pkg::byte_t   rd_data0,
    output dense_pkg::byte_t   rd_data1,
    output dense_pkg::byte_t   rd_data2
);
    import dense_pkg::*;

    byte_t mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_xfer.en) mem[wr_xfer.addr] <= wr_xfer.data;  // Host file bytes
        if (wr_mac.en) mem[wr_mac.addr] <= wr_mac.data;     // Answer bytes
        rd_data0 <= mem[rd_addr0];
        rd_data1 <= mem[rd_addr1];
        rd_data2 <= mem[rd_addr2];
    end

    // Transfer engine and dense layer take turns under the sequencer
    assert property (@(posedge clk) !(wr_xfer.en && wr_mac.en))
        else $error("both write ports enabled");

endmodule

// File: verilog/file_transfer.sv
`timescale 1ns/1ps

module file_transfer #(
    parameter int IN_LEN  = 16,
    parameter int OUT_LEN = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  dense_pkg::xfer_cmd_t cmd,
    output logic                 xfer_done,
    output dense_pkg::byte_t     tx_data,
    output logic                 tx_strobe,
    input  logic                 tx_busy,
    input  dense_pkg::byte_t     rx_data,
    input  logic                 rx_ready,
    output logic                 rx_error,
    output dense_pkg::ram_wr_t   ram_wr,
    output dense_pkg::addr_t     ram_rd_addr,
    input  dense_pkg::byte_t     ram_rd_data
);
    import dense_pkg::*;

    xfer_state_t state;
    xfer_cmd_t   cmd_q;
    addr_t       ptr;
    addr_t       remain;
    logic [1:0]  hdr_cnt;
    byte_t       hdr_byte;

    // Header, then file index high byte first
    always_comb begin
        case (hdr_cnt)
            2'd0:    hdr_byte = (cmd_q.dir == DIR_READ) ? HEAD_READ : HEAD_WRITE;
            2'd1:    hdr_byte = cmd_q.file_id[15:8];
            default: hdr_byte = cmd_q.file_id[7:0];
        endcase
    end

    assign tx_strobe   = (state == XF_HEAD || state == XF_SEND) && !tx_busy;
    assign tx_data     = (state == XF_SEND) ? ram_rd_data : hdr_byte;
    assign xfer_done   = state == XF_DONE;
    assign ram_rd_addr = ptr;  // Byte is ready one cycle ahead of XF_SEND
    assign ram_wr.en   = state == XF_RECV && rx_ready;
    assign ram_wr.addr = ptr;
    assign ram_wr.data = rx_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= XF_IDLE;
            cmd_q    <= '0;
            ptr      <= '0;
            remain   <= '0;
            hdr_cnt  <= '0;
            rx_error <= 1'b0;
        end else begin
            rx_error <= rx_ready && state != XF_RECV;  // Stray byte
            case (state)
                XF_IDLE: begin
                    if (cmd.start) begin
                        cmd_q   <= cmd;
                        ptr     <= file_base(cmd.file_id, IN_LEN, OUT_LEN);
                        remain  <= file_len(cmd.file_id, IN_LEN, OUT_LEN);
                        hdr_cnt <= '0;
                        state   <= XF_HEAD;
                    end
                end
                XF_HEAD: begin
                    if (!tx_busy) begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        // A read goes straight to receive after the low index byte
                        if (hdr_cnt == 2'd2 && cmd_q.dir == DIR_READ) begin
                            state <= XF_RECV;
                        end else begin
                            state <= XF_WAIT;
                        end
                    end
                end
                XF_WAIT: begin
                    if (!tx_busy) begin
                        if (hdr_cnt != 2'd3) begin
                            state <= XF_HEAD;
                        end else if (remain == '0) begin
                            state <= XF_DONE;
                        end else begin
                            state <= XF_SEND;
                        end
                    end
                end
                XF_SEND: begin
                    if (!tx_busy) begin
                        ptr    <= ptr + addr_t'(1);
                        remain <= remain - addr_t'(1);
                        state  <= XF_WAIT;
                    end
                end
                XF_RECV: begin
                    if (rx_ready) begin
                        ptr    <= ptr + addr_t'(1);
                        remain <= remain - addr_t'(1);
                        if (remain == addr_t'(1)) begin
                            state <= XF_DONE;
                        end
                    end
                end
                XF_DONE: state <= XF_IDLE;
                default: state <= XF_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        tx_strobe |-> !tx_busy ##1 !tx_strobe)
        else $error("tx_strobe under tx_busy or back to back");

    // Sequencer only commands an idle engine
    assert property (@(posedge clk) disable iff (reset)
        cmd.start |-> state == XF_IDLE)
        else $error("transfer command while busy");

endmodule

// File: verilog/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer #(
    parameter int IN_LEN  = 16,
    parameter int OUT_LEN = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output dense_pkg::xfer_cmd_t cmd,
    input  logic                 xfer_done,
    output logic                 mac_start,
    input  logic                 mac_done
);
    import dense_pkg::*;

    localparam int MAC_CYCLES = OUT_LEN * (IN_LEN + 3);

    seq_state_t state;

    function automatic xfer_cmd_t request(file_id_t id, link_dir_t dir);
        xfer_cmd_t c;
        c.start   = 1'b1;
        c.file_id = id;
        c.dir     = dir;
        return c;
    endfunction

    assign busy = state != SEQ_IDLE;
    assign done = state == SEQ_WR_ANSWER && xfer_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= SEQ_IDLE;
            cmd       <= '0;
            mac_start <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            mac_start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        cmd   <= request(FILE_INPUT, DIR_READ);
                        state <= SEQ_RD_INPUT;
                    end
                end
                SEQ_RD_INPUT: begin
                    if (xfer_done) begin
                        cmd   <= request(FILE_MATRIX, DIR_READ);
                        state <= SEQ_RD_MATRIX;
                    end
                end
                SEQ_RD_MATRIX: begin
                    if (xfer_done) begin
                        cmd   <= request(FILE_BIAS, DIR_READ);
                        state <= SEQ_RD_BIAS;
                    end
                end
                SEQ_RD_BIAS: begin
                    if (xfer_done) begin
                        mac_start <= 1'b1;
                        state     <= SEQ_COMPUTE;
                    end
                end
                SEQ_COMPUTE: begin
                    if (mac_done) begin
                        cmd   <= request(FILE_ANSWER, DIR_WRITE);
                        state <= SEQ_WR_ANSWER;
                    end
                end
                SEQ_WR_ANSWER: begin
                    if (xfer_done) state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        xfer_done |-> state inside {SEQ_RD_INPUT, SEQ_RD_MATRIX, SEQ_RD_BIAS, SEQ_WR_ANSWER})
        else $error("xfer_done while not waiting");

    assert property (@(posedge clk) disable iff (reset)
        mac_done |-> state == SEQ_COMPUTE)
        else $error("mac_done while not waiting");

    // Dense layer has a fixed schedule
    assert property (@(posedge clk) disable iff (reset)
        mac_start |-> ##MAC_CYCLES mac_done)
        else $error("mac_done late or missing");

endmodule

// File: verilog/dense_layer.sv
`timescale 1ns/1ps

module dense_layer #(
    parameter int IN_LEN  = 16,
    parameter int OUT_LEN = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               mac_start,
    output logic               mac_done,
    output dense_pkg::addr_t   rd_addr_in,
    output dense_pkg::addr_t   rd_addr_w,
    input  dense_pkg::byte_t   rd_data_in,
    input  dense_pkg::byte_t   rd_data_w,
    output dense_pkg::ram_wr_t ram_wr
);
    import dense_pkg::*;

    localparam addr_t IN_BASE   = file_base(FILE_INPUT, IN_LEN, OUT_LEN);
    localparam addr_t MAT_BASE  = file_base(FILE_MATRIX, IN_LEN, OUT_LEN);
    localparam addr_t BIAS_BASE = file_base(FILE_BIAS, IN_LEN, OUT_LEN);
    localparam addr_t ANS_BASE  = file_base(FILE_ANSWER, IN_LEN, OUT_LEN);

    mac_state_t state;
    addr_t      row;
    addr_t      idx;    // Input index on the read ports
    addr_t      w_ptr;  // Runs through the matrix across rows
    byte_t      acc;
    byte_t      prod;
    logic       last_row;

    assign prod       = rd_data_in * rd_data_w;  // Modulo 256
    assign last_row   = row == addr_t'(OUT_LEN - 1);
    assign rd_addr_in = IN_BASE + idx;
    assign rd_addr_w  = (state == MAC_BIAS) ? BIAS_BASE + row : MAT_BASE + w_ptr;

    assign ram_wr.en   = state == MAC_WRITE;
    assign ram_wr.addr = ANS_BASE + row;
    assign ram_wr.data = acc;
    assign mac_done    = state == MAC_WRITE && last_row;

    // Per row: bias fetch, first pair fetch, IN_LEN accumulates, write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= MAC_IDLE;
            row   <= '0;
            idx   <= '0;
            w_ptr <= '0;
        end else begin
            case (state)
                MAC_IDLE: begin
                    if (mac_start) begin
                        row   <= '0;
                        w_ptr <= '0;
                        state <= MAC_BIAS;
                    end
                end
                MAC_BIAS: begin
                    idx   <= '0;
                    state <= MAC_LOAD;
                end
                MAC_LOAD: begin
                    idx   <= idx + addr_t'(1);
                    w_ptr <= w_ptr + addr_t'(1);
                    state <= MAC_RUN;
                end
                MAC_RUN: begin
                    if (idx == addr_t'(IN_LEN)) begin
                        state <= MAC_WRITE;  // Last pair arriving now
                    end else begin
                        idx   <= idx + addr_t'(1);
                        w_ptr <= w_ptr + addr_t'(1);
                    end
                end
                MAC_WRITE: begin
                    row   <= row + addr_t'(1);
                    state <= last_row ? MAC_IDLE : MAC_BIAS;
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MAC_LOAD) begin
            acc <= rd_data_w;  // Bias byte
        end else if (state == MAC_RUN) begin
            acc <= acc + prod;
        end
    end

endmodule

// File: verilog/dense_top.sv
`timescale 1ns/1ps

module dense_top #(
    parameter int IN_LEN  = 16,
    parameter int OUT_LEN = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    output dense_pkg::byte_t tx_data,
    output logic             tx_strobe,
    input  logic             tx_busy,
    input  dense_pkg::byte_t rx_data,
    input  logic             rx_ready,
    output logic             rx_error,
    output logic             busy,
    output logic             done
);
    import dense_pkg::*;

    xfer_cmd_t cmd;
    logic      xfer_done;
    logic      mac_start;
    logic      mac_done;
    ram_wr_t   wr_xfer;
    ram_wr_t   wr_mac;
    addr_t     rd_addr0;
    addr_t     rd_addr1;
    addr_t     rd_addr2;
    byte_t     rd_data0;
    byte_t     rd_data1;
    byte_t     rd_data2;

    layer_sequencer #(.IN_LEN(IN_LEN), .OUT_LEN(OUT_LEN)) u_seq (
        .clk(clk), .reset(reset), .start(start), .busy(busy), .done(done),
        .cmd(cmd), .xfer_done(xfer_done), .mac_start(mac_start), .mac_done(mac_done)
    );

    file_transfer #(.IN_LEN(IN_LEN), .OUT_LEN(OUT_LEN)) u_xfer (
        .clk(clk), .reset(reset), .cmd(cmd), .xfer_done(xfer_done),
        .tx_data(tx_data), .tx_strobe(tx_strobe), .tx_busy(tx_busy),
        .rx_data(rx_data), .rx_ready(rx_ready), .rx_error(rx_error),
        .ram_wr(wr_xfer), .ram_rd_addr(rd_addr0), .ram_rd_data(rd_data0)
    );

    scratch_ram u_ram (
        .clk(clk), .wr_xfer(wr_xfer), .wr_mac(wr_mac),
        .rd_addr0(rd_addr0), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(rd_data2)
    );

    // Port 1 carries inputs, port 2 weights and bias
    dense_layer #(.IN_LEN(IN_LEN), .OUT_LEN(OUT_LEN)) u_mac (
        .clk(clk), .reset(reset), .mac_start(mac_start), .mac_done(mac_done),
        .rd_addr_in(rd_addr1), .rd_addr_w(rd_addr2),
        .rd_data_in(rd_data1), .rd_data_w(rd_data2), .ram_wr(wr_mac)
    );

endmodule

// File: bench/tb_dense.sv
`timescale 1ns/1ps

module tb_dense;
    import dense_pkg::*;

    localparam int IN_LEN     = 16;
    localparam int OUT_LEN    = 4;
    localparam int RUNS       = 2;
    localparam int STREAM_LEN = 12 + OUT_LEN;  // Four requests, then the answer
    localparam int LOG_LEN    = RUNS * STREAM_LEN;
    localparam int RUN_BYTES  = STREAM_LEN + IN_LEN + IN_LEN * OUT_LEN + OUT_LEN;
    localparam int MAX_GAP    = 7;
    localparam int MAC_CYCLES = OUT_LEN * (IN_LEN + 3);
    localparam int WATCHDOG   = 2 * RUNS * ((MAX_GAP + 3) * RUN_BYTES + MAC_CYCLES) + 50;

    localparam byte_t       CHAR_R    = 8'd82;
    localparam byte_t       CHAR_W    = 8'd87;
    localparam logic [15:0] ID_INPUT  = 16'd2402;
    localparam logic [15:0] ID_MATRIX = 16'd2406;
    localparam logic [15:0] ID_BIAS   = 16'd2446;
    localparam logic [15:0] ID_ANSWER = 16'd2447;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    logic  start = 1'b0;
    logic  tx_busy = 1'b0;
    byte_t rx_data = '0;
    logic  rx_ready = 1'b0;
    byte_t tx_data;
    logic  tx_strobe;
    logic  rx_error;
    logic  busy;
    logic  done;

    logic [31:0] lfsr = 32'h11d4;
    byte_t in_vec [IN_LEN];
    byte_t mat [IN_LEN * OUT_LEN];
    byte_t bias [OUT_LEN];
    byte_t exp_tx [LOG_LEN];
    byte_t tx_log [LOG_LEN];
    int    tx_cnt = 0;
    int    rd_ptr = 0;
    int    run_idx = 0;
    int    busy_left = 0;
    logic  strobe_seen = 1'b0;
    logic  stray = 1'b0;  // Marks the deliberate out-of-phase rx pulse

    dense_top #(.IN_LEN(IN_LEN), .OUT_LEN(OUT_LEN)) DUT (
        .clk(clk), .reset(reset), .start(start), .tx_data(tx_data), .tx_strobe(tx_strobe),
        .tx_busy(tx_busy), .rx_data(rx_data), .rx_ready(rx_ready), .rx_error(rx_error),
        .busy(busy), .done(done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        strobe_seen <= tx_strobe;
        if (tx_strobe && tx_cnt < LOG_LEN) begin
            tx_log[tx_cnt] <= tx_data;
        end
        if (tx_strobe) tx_cnt <= tx_cnt + 1;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output byte_t v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        $display("mismatch %s: expected %0d actual %0d", test, expected, actual);
        report_failure("check failed on a wrong value");
    endtask

    function automatic string stream_name(int idx);
        return (idx % STREAM_LEN < 12) ? "request order" : "answer value";
    endfunction

    // Host side of one falling edge, busy is held after each strobe
    task automatic next_cycle();
        byte_t hold;
        @(negedge clk);
        if (strobe_seen) begin
            draw_bits(2, hold);
            busy_left = int'(hold);
        end
        tx_busy = busy_left != 0;
        if (busy_left != 0) busy_left--;
    endtask

    function automatic int file_size(logic [15:0] id);
        case (id)
            ID_INPUT:  return IN_LEN;
            ID_MATRIX: return IN_LEN * OUT_LEN;
            ID_BIAS:   return OUT_LEN;
            default:   return 0;
        endcase
    endfunction

    function automatic byte_t file_byte(logic [15:0] id, int j);
        case (id)
            ID_INPUT:  return in_vec[j];
            ID_MATRIX: return mat[j];
            default:   return bias[j];
        endcase
    endfunction

    task automatic fill_data();
        for (int i = 0; i < IN_LEN; i++) draw_bits(8, in_vec[i]);
        for (int i = 0; i < IN_LEN * OUT_LEN; i++) draw_bits(8, mat[i]);
        for (int k = 0; k < OUT_LEN; k++) draw_bits(8, bias[k]);
    endtask

    task automatic set_request(input int at, input byte_t head, input logic [15:0] id);
        exp_tx[at]     = head;
        exp_tx[at + 1] = id[15:8];  // High byte first
        exp_tx[at + 2] = id[7:0];
    endtask

    task automatic build_expected(input int r);
        int    base;
        byte_t acc;
        base = r * STREAM_LEN;
        set_request(base, CHAR_R, ID_INPUT);
        set_request(base + 3, CHAR_R, ID_MATRIX);
        set_request(base + 6, CHAR_R, ID_BIAS);
        set_request(base + 9, CHAR_W, ID_ANSWER);
        for (int k = 0; k < OUT_LEN; k++) begin
            acc = bias[k];
            for (int i = 0; i < IN_LEN; i++) acc = acc + in_vec[i] * mat[k * IN_LEN + i];
            exp_tx[base + 12 + k] = acc;  // Wraps modulo 256
        end
    endtask

    task automatic serve_request();
        byte_t       head;
        byte_t       gap;
        logic [15:0] id;
        while (tx_cnt < rd_ptr + 3) next_cycle();
        head = tx_log[rd_ptr];
        id = {tx_log[rd_ptr + 1], tx_log[rd_ptr + 2]};
        rd_ptr += 3;
        if (head == CHAR_W) begin
            while (tx_cnt < rd_ptr + OUT_LEN) next_cycle();  // Collect the answer
            rd_ptr += OUT_LEN;
        end else begin
            for (int j = 0; j < file_size(id); j++) begin
                draw_bits(3, gap);
                repeat (int'(gap)) next_cycle();
                rx_data = file_byte(id, j);
                rx_ready = 1'b1;
                next_cycle();
                rx_ready = 1'b0;
            end
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        next_cycle();
        reset = 1'b0;
        for (int r = 0; r < RUNS; r++) begin
            run_idx = r;
            fill_data();
            build_expected(r);
            next_cycle();
            start = 1'b1;
            next_cycle();
            start = 1'b0;
            repeat (3) next_cycle();
            start = 1'b1;  // Lands while busy
            next_cycle();
            start = 1'b0;
            for (int q = 0; q < 4; q++) serve_request();
            while (busy) next_cycle();
            next_cycle();
            stray = 1'b1;
            rx_data = 8'ha5;
            rx_ready = 1'b1;
            next_cycle();
            stray = 1'b0;
            rx_ready = 1'b0;
            repeat (2) next_cycle();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        report_failure("watchdog expired before both runs finished");
    end

    assert property (@(posedge clk) $fell(reset) |-> !tx_strobe && !done && !busy && !rx_error)
        else report_failure("outputs not low after reset");

    assert property (@(posedge clk) disable iff (reset) tx_strobe |-> tx_data == exp_tx[tx_cnt])
        else report_mismatch(stream_name($sampled(tx_cnt)), exp_tx[$sampled(tx_cnt)],
                             $sampled(tx_data));

    assert property (@(posedge clk) disable iff (reset)
        tx_strobe |-> tx_cnt < (run_idx + 1) * STREAM_LEN)
        else report_failure("extra byte transmitted within a run");

    assert property (@(posedge clk) disable iff (reset) tx_strobe |-> !tx_busy)
        else report_failure("tx_strobe while tx_busy is high");

    assert property (@(posedge clk) disable iff (reset) tx_strobe |=> !tx_strobe)
        else report_failure("tx_strobe in the cycle after a strobe");

    assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
        else report_failure("busy did not rise after start");

    assert property (@(posedge clk) disable iff (reset) $rose(busy) |-> $past(start))
        else report_failure("busy rose without start");

    assert property (@(posedge clk) disable iff (reset) done |-> busy ##1 !busy && !done)
        else report_failure("done not a single cycle at the end of busy");

    assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> $past(done))
        else report_failure("busy fell without done");

    assert property (@(posedge clk) disable iff (reset)
        done |-> tx_cnt == (run_idx + 1) * STREAM_LEN)
        else report_mismatch("answer length", (run_idx + 1) * STREAM_LEN, $sampled(tx_cnt));

    assert property (@(posedge clk) disable iff (reset) rx_ready && stray |=> rx_error)
        else report_failure("stray rx_ready did not raise rx_error");

    assert property (@(posedge clk) disable iff (reset) rx_error |-> $past(rx_ready && stray))
        else report_failure("rx_error without a stray rx_ready pulse");

endmodule

// File: flist.f
verilog/dense_pkg.sv
verilog/scratch_ram.sv
verilog/file_transfer.sv
verilog/layer_sequencer.sv
verilog/dense_layer.sv
verilog/dense_top.sv
bench/tb_dense.sv

// File: run.sh
#!/bin/sh
# Build and run the dense layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_dense -f flist.f -o tb_dense > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dense > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
